// ==== logic/csr_bank.sv ====
/*
 * Machine CSR bank top level
 *   access decoder, trap registers, counters, interrupt control
 */

`timescale 1ns/1ps

`include "csr_cfg.svh"

`default_nettype none

module csr_bank
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  var csr_req_t         req_i,
    input  var trap_req_t        trap_i,
    input  logic [`CSR_XLEN-1:0] irq_i,
    output logic [`CSR_XLEN-1:0] rdata_o,
    output logic                 irq_pending_o,
    output priv_e                priv_o,
    output logic [`CSR_XLEN-1:0] mepc_o,
    output logic [`CSR_XLEN-1:0] mtvec_o
);

    csr_view_t              view;
    csr_wr_sel_t            wr_sel;
    logic [`CSR_XLEN-1:0]   wdata;
    mstatus_t               mstatus;
    logic [`CSR_XLEN-1:0]   mie, mip, mtvec, mscratch, mepc, mcause, mtval;
    logic [2*`CSR_XLEN-1:0] mcycle, minstret;
    irq_code_e              irq_code;

    csr_decode u_decode (
        .req_i    (req_i),
        .trap_i   (trap_i),
        .view_i   (view),
        .wdata_o  (wdata),
        .wr_sel_o (wr_sel),
        .rdata_o  (rdata_o)
    );

    csr_machine_regs u_machine_regs (
        .clk        (clk),
        .reset_n    (reset_n),
        .trap_i     (trap_i),
        .irq_code_i (irq_code),
        .wdata_i    (wdata),
        .wr_sel_i   (wr_sel),
        .mstatus_o  (mstatus),
        .mie_o      (mie),
        .mtvec_o    (mtvec),
        .mscratch_o (mscratch),
        .mepc_o     (mepc),
        .mcause_o   (mcause),
        .mtval_o    (mtval),
        .priv_o     (priv_o)
    );

    csr_counters u_counters (
        .clk        (clk),
        .reset_n    (reset_n),
        .kill_i     (req_i.kill),
        .wdata_i    (wdata),
        .wr_sel_i   (wr_sel),
        .mcycle_o   (mcycle),
        .minstret_o (minstret)
    );

    csr_irq_ctrl u_irq_ctrl (
        .clk           (clk),
        .reset_n       (reset_n),
        .irq_i         (irq_i),
        .mie_i         (mie),
        .glb_ie_i      (mstatus.fields.mie),     // Global machine enable
        .irq_ack_i     (trap_i.irq_ack),
        .mip_o         (mip),
        .irq_pending_o (irq_pending_o),
        .irq_code_o    (irq_code)
    );

    //////////////////////////////
    // Register view for reads
    //////////////////////////////

    always_comb begin
        view.mstatus  = mstatus;
        view.mie      = mie;
        view.mip      = mip;
        view.mtvec    = mtvec;
        view.mscratch = mscratch;
        view.mepc     = mepc;
        view.mcause   = mcause;
        view.mtval    = mtval;
        view.mcycle   = mcycle;
        view.minstret = minstret;
    end

    assign mepc_o  = mepc;
    assign mtvec_o = mtvec;

endmodule

`default_nettype wire

// ==== logic/csr_cfg.svh ====
/*
 * Configuration macros of the machine CSR bank
 *   data and address widths, reset privilege
 *   compressed-extension option and alignment mask
 *   constant misa word and writable-bit masks
 */

`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

`default_nettype none

`define CSR_XLEN        32
`define CSR_ADDR_W      12
`define CSR_RESET_PRIV  2'b11               // Machine mode out of reset

// 1 when the core executes 16-bit instructions
`define CSR_COMPRESSED  0

// MXL = 1, U and I extensions
`define CSR_MISA_VALUE  32'h4010_0100

// TSR, TW, TVM, SUM, MPP, MPIE and MIE only
`define CSR_MASK_MSTATUS 32'h0074_1888
`define CSR_MASK_MIE     32'h0000_0888     // MEIE, MTIE, MSIE

`define CSR_MASK_ALIGN  ((`CSR_COMPRESSED) ? 32'hFFFF_FFFE : 32'hFFFF_FFFC)

`default_nettype wire

`endif

// ==== logic/csr_counters.sv ====
/*
 * Cycle and retired-instruction counters
 *   64-bit mcycle and minstret with half-word writes
 */

`timescale 1ns/1ps

`include "csr_cfg.svh"

`default_nettype none

module csr_counters
    import csr_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   kill_i,
    input  logic [`CSR_XLEN-1:0]   wdata_i,
    input  var csr_wr_sel_t        wr_sel_i,
    output logic [2*`CSR_XLEN-1:0] mcycle_o,
    output logic [2*`CSR_XLEN-1:0] minstret_o
);

    logic [2*`CSR_XLEN-1:0] mcycle_q, minstret_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end
        else begin
            // A half write skips the increment for this edge
            if (wr_sel_i.mcycle_lo)
                mcycle_q <= {mcycle_q[2*`CSR_XLEN-1:`CSR_XLEN], wdata_i};
            else if (wr_sel_i.mcycle_hi)
                mcycle_q <= {wdata_i, mcycle_q[`CSR_XLEN-1:0]};
            else
                mcycle_q <= mcycle_q + 1'b1;

            if (wr_sel_i.minstret_lo)
                minstret_q <= {minstret_q[2*`CSR_XLEN-1:`CSR_XLEN], wdata_i};
            else if (wr_sel_i.minstret_hi)
                minstret_q <= {wdata_i, minstret_q[`CSR_XLEN-1:0]};
            else if (!kill_i)
                minstret_q <= minstret_q + 1'b1;   // Killed ones do not retire
        end
    end

    assign mcycle_o   = mcycle_q;
    assign minstret_o = minstret_q;

endmodule

`default_nettype wire

// ==== logic/csr_decode.sv ====
/*
 * CSR access decoder
 *   address decode with current value and write mask
 *   write, set and clear data computation
 *   gated per-register write strobes
 *   read multiplexer with misa, IDs and counter aliases
 */

`timescale 1ns/1ps

`include "csr_cfg.svh"

`default_nettype none

module csr_decode
    import csr_pkg::*;
(
    input  var csr_req_t             req_i,
    input  var trap_req_t            trap_i,
    input  var csr_view_t            view_i,
    output logic [`CSR_XLEN-1:0]     wdata_o,
    output csr_wr_sel_t              wr_sel_o,
    output logic [`CSR_XLEN-1:0]     rdata_o
);

    csr_addr_e            addr;
    logic [`CSR_XLEN-1:0] cur_val;
    logic [`CSR_XLEN-1:0] wmask;
    csr_wr_sel_t          sel;
    logic                 trap_any;
    logic                 wr_en;
    logic                 rd_en;

    assign addr = csr_addr_e'(req_i.addr);

    //////////////////////////////
    // Current value and mask
    //////////////////////////////

    always_comb begin
        sel     = '0;
        wmask   = '0;                       // Read-only unless listed
        cur_val = '0;
        case (addr)
            MSTATUS: begin
                cur_val     = view_i.mstatus.raw;
                wmask       = `CSR_MASK_MSTATUS;
                sel.mstatus = 1'b1;
            end
            MISA:      cur_val = `CSR_MISA_VALUE;
            MIE: begin
                cur_val = view_i.mie;
                wmask   = `CSR_MASK_MIE;
                sel.mie = 1'b1;
            end
            MTVEC: begin
                cur_val   = view_i.mtvec;
                wmask     = `CSR_MASK_ALIGN;
                sel.mtvec = 1'b1;
            end
            MSCRATCH: begin
                cur_val      = view_i.mscratch;
                wmask        = '1;
                sel.mscratch = 1'b1;
            end
            MEPC: begin
                cur_val  = view_i.mepc;
                wmask    = `CSR_MASK_ALIGN;
                sel.mepc = 1'b1;
            end
            MCAUSE: begin
                cur_val    = view_i.mcause;
                wmask      = '1;
                sel.mcause = 1'b1;
            end
            MTVAL: begin
                cur_val   = view_i.mtval;
                wmask     = '1;
                sel.mtval = 1'b1;
            end
            MIP:       cur_val = view_i.mip;
            MCYCLE: begin
                cur_val       = view_i.mcycle[`CSR_XLEN-1:0];
                wmask         = '1;
                sel.mcycle_lo = 1'b1;
            end
            MCYCLEH: begin
                cur_val       = view_i.mcycle[2*`CSR_XLEN-1:`CSR_XLEN];
                wmask         = '1;
                sel.mcycle_hi = 1'b1;
            end
            MINSTRET: begin
                cur_val         = view_i.minstret[`CSR_XLEN-1:0];
                wmask           = '1;
                sel.minstret_lo = 1'b1;
            end
            MINSTRETH: begin
                cur_val         = view_i.minstret[2*`CSR_XLEN-1:`CSR_XLEN];
                wmask           = '1;
                sel.minstret_hi = 1'b1;
            end
            CYCLE:     cur_val = view_i.mcycle[`CSR_XLEN-1:0];
            CYCLEH:    cur_val = view_i.mcycle[2*`CSR_XLEN-1:`CSR_XLEN];
            INSTRET:   cur_val = view_i.minstret[`CSR_XLEN-1:0];
            INSTRETH:  cur_val = view_i.minstret[2*`CSR_XLEN-1:`CSR_XLEN];
            default:   cur_val = '0;   // IDs and unknown addresses
        endcase
    end

    //////////////////////////////
    // New value
    //////////////////////////////

    always_comb begin
        case (req_i.op)
            CSR_SET:   wdata_o = cur_val | (req_i.data & wmask);
            CSR_CLEAR: wdata_o = cur_val & ~(req_i.data & wmask);
            default:   wdata_o = (cur_val & ~wmask) | (req_i.data & wmask);
        endcase
    end

    // Trap events outrank any CSR write
    assign trap_any = trap_i.raise | trap_i.mret | trap_i.irq_ack;
    assign wr_en    = req_i.write & ~req_i.kill & ~trap_any;
    assign rd_en    = req_i.read & ~req_i.kill;

    assign wr_sel_o = wr_en ? sel : '0;
    assign rdata_o  = rd_en ? cur_val : '0;

endmodule

`default_nettype wire

// ==== logic/csr_irq_ctrl.sv ====
/*
 * Interrupt control
 *   mip sampling of the request lines
 *   registered pending flag and cause priority encoder
 */

`timescale 1ns/1ps

`include "csr_cfg.svh"

`default_nettype none

module csr_irq_ctrl
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic [`CSR_XLEN-1:0] irq_i,
    input  logic [`CSR_XLEN-1:0] mie_i,
    input  logic                 glb_ie_i,
    input  logic                 irq_ack_i,
    output logic [`CSR_XLEN-1:0] mip_o,
    output logic                 irq_pending_o,
    output irq_code_e            irq_code_o
);

    logic [`CSR_XLEN-1:0] mip_q;
    logic [`CSR_XLEN-1:0] active;
    logic                 pending_d;
    logic                 pending_q;
    irq_code_e            code_d, code_q;

    assign active    = mie_i & mip_q;
    assign pending_d = glb_ie_i && (|active) && !irq_ack_i;

    // External first, then software, then timer
    always_comb begin
        if (active[M_EXT_INT])      code_d = M_EXT_INT;
        else if (active[M_SW_INT])  code_d = M_SW_INT;
        else if (active[M_TIM_INT]) code_d = M_TIM_INT;
        else                        code_d = code_q;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mip_q     <= '0;
            pending_q <= 1'b0;
            code_q    <= M_SW_INT;
        end
        else begin
            mip_q     <= irq_i;
            pending_q <= pending_d;
            if (pending_d)
                code_q <= code_d;
        end
    end

    assign mip_o         = mip_q;
    assign irq_pending_o = pending_q;
    assign irq_code_o    = code_q;

    // Reported cause was enabled and set at the sampling edge
    assert property (@(posedge clk) disable iff (!reset_n)
        irq_pending_o |-> |($past(active) & (`CSR_XLEN'(1) << irq_code_o)));

endmodule

`default_nettype wire

// ==== logic/csr_machine_regs.sv ====
/*
 * Machine trap registers
 *   mstatus, mie, mtvec, mscratch, mepc, mcause, mtval
 *   current privilege level
 *   exception and interrupt entry, machine return
 */

`timescale 1ns/1ps

`include "csr_cfg.svh"

`default_nettype none

module csr_machine_regs
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  var trap_req_t        trap_i,
    input  var irq_code_e        irq_code_i,
    input  logic [`CSR_XLEN-1:0] wdata_i,
    input  var csr_wr_sel_t      wr_sel_i,
    output mstatus_t             mstatus_o,
    output logic [`CSR_XLEN-1:0] mie_o,
    output logic [`CSR_XLEN-1:0] mtvec_o,
    output logic [`CSR_XLEN-1:0] mscratch_o,
    output logic [`CSR_XLEN-1:0] mepc_o,
    output logic [`CSR_XLEN-1:0] mcause_o,
    output logic [`CSR_XLEN-1:0] mtval_o,
    output priv_e                priv_o
);

    mstatus_t             mstatus_q;
    logic [`CSR_XLEN-1:0] mie_q, mtvec_q, mscratch_q, mepc_q, mcause_q, mtval_q;
    priv_e                priv_q;
    logic [`CSR_XLEN-1:0] irq_mepc;
    logic [`CSR_XLEN-1:0] irq_step;

    // The interrupted instruction retires, so return to the one after it
    assign irq_step = (`CSR_COMPRESSED && trap_i.compressed) ? `CSR_XLEN'(2) : `CSR_XLEN'(4);
    assign irq_mepc = trap_i.jump ? trap_i.jump_target : trap_i.pc + irq_step;

    //////////////////////////////
    // Register update
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mstatus_q  <= '0;
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
            priv_q     <= priv_e'(`CSR_RESET_PRIV);
        end
        else if (trap_i.mret) begin
            mstatus_q.fields.mie <= mstatus_q.fields.mpie;
            priv_q <= (mstatus_q.fields.mpp == PRIV_M) ? PRIV_M : PRIV_U;
        end
        else if (trap_i.raise || trap_i.irq_ack) begin
            mstatus_q.fields.mpp  <= priv_q;                // Save context
            mstatus_q.fields.mpie <= mstatus_q.fields.mie;
            mstatus_q.fields.mie  <= 1'b0;
            priv_q                <= PRIV_M;
            if (trap_i.raise) begin
                mcause_q <= {1'b0, {(`CSR_XLEN-6){1'b0}}, trap_i.exc_code};
                mepc_q   <= trap_i.pc;
                mtval_q  <= (trap_i.exc_code == ILLEGAL_INSTRUCTION)
                            ? trap_i.instr
                            : trap_i.pc;
            end
            else begin
                mcause_q <= {1'b1, {(`CSR_XLEN-6){1'b0}}, irq_code_i};
                mepc_q   <= irq_mepc;
            end
        end
        else begin
            if (wr_sel_i.mstatus)  mstatus_q.raw <= wdata_i;
            if (wr_sel_i.mie)      mie_q         <= wdata_i;
            if (wr_sel_i.mtvec)    mtvec_q       <= wdata_i;
            if (wr_sel_i.mscratch) mscratch_q    <= wdata_i;
            if (wr_sel_i.mepc)     mepc_q        <= wdata_i;
            if (wr_sel_i.mcause)   mcause_q      <= wdata_i;
            if (wr_sel_i.mtval)    mtval_q       <= wdata_i;
        end
    end

    assign mstatus_o  = mstatus_q;
    assign mie_o      = mie_q;
    assign mtvec_o    = mtvec_q;
    assign mscratch_o = mscratch_q;
    assign mepc_o     = mepc_q;
    assign mcause_o   = mcause_q;
    assign mtval_o    = mtval_q;
    assign priv_o     = priv_q;

    // The pipeline never takes an interrupt on a faulting instruction
    assert property (@(posedge clk) disable iff (!reset_n)
        !(trap_i.raise && trap_i.irq_ack));

endmodule

`default_nettype wire

// ==== logic/csr_pkg.sv ====
/*
 * Types shared by the CSR bank
 *   address, operation, privilege and cause encodings
 *   mstatus word with its field view
 *   request, trap, strobe and register view structs
 */

`include "csr_cfg.svh"

`default_nettype none

package csr_pkg;

    typedef enum logic [`CSR_ADDR_W-1:0] {
        MSTATUS    = 12'h300,
        MISA       = 12'h301,
        MIE        = 12'h304,
        MTVEC      = 12'h305,
        MSCRATCH   = 12'h340,
        MEPC       = 12'h341,
        MCAUSE     = 12'h342,
        MTVAL      = 12'h343,
        MIP        = 12'h344,
        MCYCLE     = 12'hB00,
        MINSTRET   = 12'hB02,
        MCYCLEH    = 12'hB80,
        MINSTRETH  = 12'hB82,
        CYCLE      = 12'hC00,   // User read-only aliases
        INSTRET    = 12'hC02,
        CYCLEH     = 12'hC80,
        INSTRETH   = 12'hC82,
        MVENDORID  = 12'hF11,
        MARCHID    = 12'hF12,
        MIMPID     = 12'hF13,
        MHARTID    = 12'hF14,
        MCONFIGPTR = 12'hF15
    } csr_addr_e;

    typedef enum logic [1:0] {
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_e;

    typedef enum logic [4:0] {
        INSTR_ADDR_MISALIGNED = 5'd0,
        INSTR_ACCESS_FAULT    = 5'd1,
        ILLEGAL_INSTRUCTION   = 5'd2,
        BREAKPOINT            = 5'd3,
        LOAD_ADDR_MISALIGNED  = 5'd4,
        LOAD_ACCESS_FAULT     = 5'd5,
        STORE_ADDR_MISALIGNED = 5'd6,
        STORE_ACCESS_FAULT    = 5'd7,
        ECALL_FROM_UMODE      = 5'd8,
        ECALL_FROM_MMODE      = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    //////////////////////////////
    // mstatus
    //////////////////////////////

    typedef struct packed {
        logic       sd;
        logic [7:0] rsv_30_23;
        logic       tsr;
        logic       tw;
        logic       tvm;
        logic       rsv_19;     // MXR not implemented
        logic       sum;
        logic       rsv_17;     // MPRV not implemented
        logic [1:0] xs;
        logic [1:0] fs;
        logic [1:0] mpp;
        logic [1:0] vs;
        logic       rsv_8;
        logic       mpie;
        logic       ube;
        logic [1:0] rsv_5_4;
        logic       mie;
        logic [2:0] rsv_2_0;
    } mstatus_fields_t;

    typedef union packed {
        logic [`CSR_XLEN-1:0] raw;
        mstatus_fields_t      fields;
    } mstatus_t;

    //////////////////////////////
    // Transport structs
    //////////////////////////////

    typedef struct packed {
        logic                   read;
        logic                   write;
        logic                   kill;       // Instruction squashed in the pipe
        csr_op_e                op;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`CSR_XLEN-1:0]   data;
    } csr_req_t;

    typedef struct packed {
        logic                 raise;
        logic                 mret;
        logic                 irq_ack;
        exc_code_e            exc_code;
        logic [`CSR_XLEN-1:0] pc;
        logic [`CSR_XLEN-1:0] instr;
        logic                 compressed;
        logic                 jump;
        logic [`CSR_XLEN-1:0] jump_target;
    } trap_req_t;

    typedef struct packed {
        logic mstatus;
        logic mie;
        logic mtvec;
        logic mscratch;
        logic mepc;
        logic mcause;
        logic mtval;
        logic mcycle_lo;
        logic mcycle_hi;
        logic minstret_lo;
        logic minstret_hi;
    } csr_wr_sel_t;

    typedef struct packed {
        mstatus_t               mstatus;
        logic [`CSR_XLEN-1:0]   mie;
        logic [`CSR_XLEN-1:0]   mip;
        logic [`CSR_XLEN-1:0]   mtvec;
        logic [`CSR_XLEN-1:0]   mscratch;
        logic [`CSR_XLEN-1:0]   mepc;
        logic [`CSR_XLEN-1:0]   mcause;
        logic [`CSR_XLEN-1:0]   mtval;
        logic [2*`CSR_XLEN-1:0] mcycle;
        logic [2*`CSR_XLEN-1:0] minstret;
    } csr_view_t;

endpackage

`default_nettype wire

// ==== testbench/csr_tb_checks.svh ====
/*
 * Compare tasks for the CSR bank testbench
 *   error and check counters
 *   word, privilege and single-bit compares
 */

`ifndef CSR_TB_CHECKS_SVH
`define CSR_TB_CHECKS_SVH

int err_count   = 0;
int check_count = 0;

task automatic check_word(input string name, input logic [`CSR_XLEN-1:0] exp,
                          input logic [`CSR_XLEN-1:0] act);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("ERR %0d ns %s expected %h actual %h", $time, name, exp, act);
    end
endtask

task automatic check_priv(input string name, input priv_e exp, input priv_e act);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("ERR %0d ns %s expected %b actual %b", $time, name, exp, act);
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("ERR %0d ns %s expected %b actual %b", $time, name, exp, act);
    end
endtask

`endif

// ==== testbench/csr_bank_tb.sv ====
/*
 * Testbench for the machine CSR bank
 *   stimulus table built from the access, trap and interrupt rules
 *   one row per rising edge, checks at the falling edge
 *   watchdog and closing report
 */

`timescale 1ns/1ps

`include "csr_cfg.svh"

`default_nettype none

module csr_bank_tb
    import csr_pkg::*;
();

    typedef struct packed {
        csr_req_t             req;
        trap_req_t            trap;
        logic [`CSR_XLEN-1:0] irq;
        logic [`CSR_XLEN-1:0] exp_rdata;
        priv_e                exp_priv;
        logic [`CSR_XLEN-1:0] exp_mepc;
        logic [`CSR_XLEN-1:0] exp_mtvec;
        logic                 exp_pend;
    } row_t;

    logic                 clk;
    logic                 reset_n;
    csr_req_t             req;
    trap_req_t            trap;
    logic [`CSR_XLEN-1:0] irq;
    logic [`CSR_XLEN-1:0] rdata;
    logic                 irq_pending;
    priv_e                priv;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mtvec;

    row_t                 rows[$];
    logic                 rows_ready = 1'b0;
    logic [31:0]          rng_state  = 32'd2968;

    // Expected state while the table is built
    priv_e                e_priv;
    logic [`CSR_XLEN-1:0] e_mepc;
    logic [`CSR_XLEN-1:0] e_mtvec;
    logic                 e_pend;
    logic [`CSR_XLEN-1:0] irq_lines;

    `include "csr_tb_checks.svh"

    tb_clock_gen u_clock_gen (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    csr_bank dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .req_i         (req),
        .trap_i        (trap),
        .irq_i         (irq),
        .rdata_o       (rdata),
        .irq_pending_o (irq_pending),
        .priv_o        (priv),
        .mepc_o        (mepc),
        .mtvec_o       (mtvec)
    );

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [`CSR_XLEN-1:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic csr_req_t read_req(input logic [`CSR_ADDR_W-1:0] addr);
        csr_req_t r;
        r      = '0;
        r.read = 1'b1;
        r.op   = CSR_WRITE;
        r.addr = addr;
        return r;
    endfunction

    function automatic csr_req_t write_req(input csr_op_e op, input logic [`CSR_ADDR_W-1:0] addr,
                                           input logic [`CSR_XLEN-1:0] data);
        csr_req_t r;
        r       = '0;
        r.write = 1'b1;
        r.op    = op;
        r.addr  = addr;
        r.data  = data;
        return r;
    endfunction

    function automatic trap_req_t exc_event(input exc_code_e code, input logic [`CSR_XLEN-1:0] pc,
                                            input logic [`CSR_XLEN-1:0] instr);
        trap_req_t t;
        t          = '0;
        t.raise    = 1'b1;
        t.exc_code = code;
        t.pc       = pc;
        t.instr    = instr;
        return t;
    endfunction

    function automatic trap_req_t ack_event(input logic [`CSR_XLEN-1:0] pc, input logic jump,
                                            input logic [`CSR_XLEN-1:0] target);
        trap_req_t t;
        t             = '0;
        t.irq_ack     = 1'b1;
        t.pc          = pc;
        t.jump        = jump;
        t.jump_target = target;
        return t;
    endfunction

    function automatic trap_req_t mret_event();
        trap_req_t t;
        t      = '0;
        t.mret = 1'b1;
        return t;
    endfunction

    task automatic add_row(input csr_req_t rq, input trap_req_t tr,
                           input logic [`CSR_XLEN-1:0] exp_rd);
        row_t r;
        r.req       = rq;
        r.trap      = tr;
        r.irq       = irq_lines;
        r.exp_rdata = exp_rd;
        r.exp_priv  = e_priv;
        r.exp_mepc  = e_mepc;
        r.exp_mtvec = e_mtvec;
        r.exp_pend  = e_pend;
        rows.push_back(r);
    endtask

    // Access row, then a read row that expects the masked result
    task automatic op_then_read(input csr_op_e op, input logic [`CSR_ADDR_W-1:0] addr,
                                input logic [`CSR_XLEN-1:0] data,
                                input logic [`CSR_XLEN-1:0] mask,
                                inout logic [`CSR_XLEN-1:0] model);
        add_row(write_req(op, addr, data), '0, '0);
        case (op)
            CSR_SET:   model = model | (data & mask);
            CSR_CLEAR: model = model & ~(data & mask);
            default:   model = (model & ~mask) | (data & mask);
        endcase
        if (addr == MTVEC)
            e_mtvec = model;                            // Seen on mtvec_o from the next edge
        add_row(read_req(addr), '0, model);
    endtask

    //////////////////////////////
    // Stimulus table
    //////////////////////////////

    task automatic build_rows();
        logic [`CSR_ADDR_W-1:0] op_addr [3];
        logic [`CSR_XLEN-1:0]   op_mask [3];
        logic [`CSR_XLEN-1:0]   model   [3];
        csr_op_e                ops     [3];
        logic [`CSR_XLEN-1:0]   x;
        mstatus_t               ms;
        csr_req_t               rq;

        op_addr   = '{MSCRATCH, MIE, MTVEC};
        op_mask   = '{32'hFFFF_FFFF, `CSR_MASK_MIE, `CSR_MASK_ALIGN};
        model     = '{32'h0, 32'h0, 32'h0};
        ops       = '{CSR_WRITE, CSR_SET, CSR_CLEAR};
        e_priv    = PRIV_M;
        e_mepc    = '0;
        e_mtvec   = '0;
        e_pend    = 1'b0;
        irq_lines = '0;

        // Write, set and clear with read-back
        for (int r = 0; r < 3; r++) begin
            for (int o = 0; o < 3; o++) begin
                op_then_read(ops[o], op_addr[r], rand_word(), op_mask[r], model[r]);
            end
        end
        rq      = write_req(CSR_WRITE, MSCRATCH, rand_word());
        rq.read = 1'b1;
        rq.kill = 1'b1;
        add_row(rq, '0, '0);                            // Killed, no write and no read
        add_row(read_req(MSCRATCH), '0, model[0]);

        // Exceptions
        add_row('0, exc_event(ILLEGAL_INSTRUCTION, 32'h0000_0100, 32'hBADC_0DE3), '0);
        e_mepc = 32'h0000_0100;
        add_row(read_req(MEPC), '0, 32'h0000_0100);
        add_row(read_req(MTVAL), '0, 32'hBADC_0DE3);    // Faulting instruction word
        add_row(read_req(MCAUSE), '0, 32'(ILLEGAL_INSTRUCTION));
        add_row('0, exc_event(LOAD_ACCESS_FAULT, 32'h0000_0204, 32'h1234_5678), '0);
        e_mepc = 32'h0000_0204;
        add_row(read_req(MTVAL), '0, 32'h0000_0204);
        add_row(read_req(MCAUSE), '0, 32'(LOAD_ACCESS_FAULT));

        // mret back to user mode
        ms             = '0;
        ms.fields.mpp  = PRIV_U;
        ms.fields.mpie = 1'b1;
        add_row(write_req(CSR_WRITE, MSTATUS, ms.raw), '0, '0);
        add_row(read_req(MSTATUS), '0, ms.raw);
        add_row('0, mret_event(), '0);
        e_priv        = PRIV_U;
        ms.fields.mie = 1'b1;                           // Restored from mpie
        add_row(read_req(MSTATUS), '0, ms.raw);

        // Interrupts, external and timer together
        add_row(write_req(CSR_WRITE, MIE, `CSR_MASK_MIE), '0, '0);
        irq_lines = 32'h0000_0880;
        add_row('0, '0, '0);
        add_row(read_req(MIP), '0, 32'h0000_0880);
        e_pend = 1'b1;
        add_row('0, '0, '0);
        add_row('0, ack_event(32'h0000_0300, 1'b0, '0), '0);
        e_pend = 1'b0;
        e_priv = PRIV_M;
        e_mepc = 32'h0000_0300 + 32'd4;
        add_row(read_req(MCAUSE), '0, {1'b1, 26'd0, M_EXT_INT});
        add_row('0, mret_event(), '0);
        e_priv = PRIV_U;
        add_row('0, '0, '0);                            // Global enable back on
        e_pend = 1'b1;
        add_row('0, '0, '0);
        add_row('0, ack_event(32'h0000_0500, 1'b1, 32'h0000_0400), '0);
        e_pend    = 1'b0;
        e_priv    = PRIV_M;
        e_mepc    = 32'h0000_0400;
        irq_lines = '0;
        add_row(read_req(MCAUSE), '0, {1'b1, 26'd0, M_EXT_INT});

        // Counters
        x = rand_word();
        add_row(write_req(CSR_WRITE, MCYCLE, x), '0, '0);
        add_row(read_req(MCYCLE), '0, x);
        add_row(read_req(CYCLE), '0, x + 32'd1);
        x = rand_word();
        add_row(write_req(CSR_WRITE, MCYCLEH, x), '0, '0);
        add_row(read_req(CYCLEH), '0, x);
        x = rand_word();
        add_row(write_req(CSR_WRITE, MINSTRET, x), '0, '0);
        add_row(read_req(MINSTRET), '0, x);
        rq      = read_req(MINSTRET);
        rq.kill = 1'b1;
        add_row(rq, '0, '0);
        add_row(read_req(INSTRET), '0, x + 32'd1);      // Killed row did not retire

        // Unknown address, IDs and misa
        add_row(read_req(12'h7C0), '0, '0);
        add_row(read_req(MVENDORID), '0, '0);
        add_row(read_req(MISA), '0, `CSR_MISA_VALUE);
        add_row(write_req(CSR_WRITE, MISA, 32'hFFFF_FFFF), '0, '0);
        add_row(read_req(MISA), '0, `CSR_MISA_VALUE);
    endtask

    //////////////////////////////
    // Apply loop and report
    //////////////////////////////

    initial begin : main
        req  = '0;
        trap = '0;
        irq  = '0;
        build_rows();
        rows_ready = 1'b1;
        wait (reset_n === 1'b1);
        foreach (rows[i]) begin
            @(posedge clk);
            req  <= rows[i].req;
            trap <= rows[i].trap;
            irq  <= rows[i].irq;
            @(negedge clk);                             // Outputs settled mid-cycle
            check_word("rdata_o", rows[i].exp_rdata, rdata);
            check_priv("priv_o", rows[i].exp_priv, priv);
            check_word("mepc_o", rows[i].exp_mepc, mepc);
            check_word("mtvec_o", rows[i].exp_mtvec, mtvec);
            check_bit("irq_pending_o", rows[i].exp_pend, irq_pending);
        end
        @(posedge clk);
        req  <= '0;
        trap <= '0;
        irq  <= '0;
        $display("Rows %0d, checks %0d, errors %0d", rows.size(), check_count, err_count);
        if (err_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial begin : watchdog
        wait (rows_ready);
        #((rows.size() + 20) * 20);
        $display("Timeout after %0d cycles, table not finished", rows.size() + 20);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
/*
 * Clock and reset generator for the CSR bank testbench
 *   20 ns clock, active-low reset held for 3 cycles
 */

`timescale 1ns/1ps

`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic reset_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;     // 20 ns period
    end

    initial begin
        reset_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        reset_n_o <= 1'b1;              // Release on an edge, flops still see reset
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
+incdir+testbench
logic/csr_pkg.sv
logic/csr_decode.sv
logic/csr_machine_regs.sv
logic/csr_counters.sv
logic/csr_irq_ctrl.sv
logic/csr_bank.sv
testbench/tb_clock_gen.sv
testbench/csr_bank_tb.sv
